/* hw/deu_defs.svh */
`ifndef DEU_DEFS_SVH
`define DEU_DEFS_SVH

`define DEU_XLEN      32
`define DEU_REG_W     5
`define DEU_ALU_OP_W  6
`define DEU_MASK_W    4
`define DEU_CMP_W     3

// major opcodes
`define DEU_OP_LUI    7'b0110111
`define DEU_OP_AUIPC  7'b0010111
`define DEU_OP_JAL    7'b1101111
`define DEU_OP_JALR   7'b1100111
`define DEU_OP_LOAD   7'b0000011
`define DEU_OP_STORE  7'b0100011
`define DEU_OP_BRANCH 7'b1100011
`define DEU_OP_IMM    7'b0010011
`define DEU_OP_REG    7'b0110011

// alu operation codes
`define DEU_ALU_ADD   6'b110000
`define DEU_ALU_SUB   6'b110001
`define DEU_ALU_XOR   6'b010110
`define DEU_ALU_OR    6'b011110
`define DEU_ALU_AND   6'b011000
`define DEU_ALU_SLL   6'b100000
`define DEU_ALU_SRL   6'b100001
`define DEU_ALU_SRA   6'b100011

// compare functions
`define DEU_CMP_EQ    3'b000
`define DEU_CMP_NE    3'b001
`define DEU_CMP_LT    3'b011
`define DEU_CMP_GE    3'b010
`define DEU_CMP_LTU   3'b101
`define DEU_CMP_GEU   3'b110

`endif

/* hw/deu_pkg.sv */
`include "deu_defs.svh"

package deu_pkg;

    // data word or address
    typedef logic [`DEU_XLEN-1:0] word_t;

    // architectural register index
    typedef logic [`DEU_REG_W-1:0] reg_idx_t;

    typedef logic [`DEU_ALU_OP_W-1:0] alu_op_t;

    // one bit per byte lane
    typedef logic [`DEU_MASK_W-1:0] mem_mask_t;

    typedef logic [`DEU_CMP_W-1:0] cmp_fn_t;

endpackage

/* hw/deu_stage_if.sv */
`timescale 1ns/100ps

// capture to decode
interface fetch_if;
    logic          valid;
    deu_pkg::word_t pc;
    deu_pkg::word_t snpc;
    deu_pkg::word_t inst;
    deu_pkg::word_t rs1_value;
    deu_pkg::word_t rs2_value;

    modport src (output valid, pc, snpc, inst, rs1_value, rs2_value);
    modport dst (input valid, pc, snpc, inst, rs1_value, rs2_value);
endinterface

// decode to operand select
interface decoded_if;
    logic                valid;
    deu_pkg::word_t      pc;
    deu_pkg::word_t      snpc;
    deu_pkg::word_t      rs1_value;
    deu_pkg::word_t      rs2_value;
    deu_pkg::word_t      imm;
    deu_pkg::alu_op_t    alu_op;
    deu_pkg::cmp_fn_t    cmp_fn;
    deu_pkg::mem_mask_t  mem_re;
    deu_pkg::mem_mask_t  mem_we;
    deu_pkg::reg_idx_t   rd;
    logic                src1_is_pc;
    logic                src1_is_zero;
    logic                src2_is_imm;
    logic                is_branch;
    logic                is_jump;
    logic                is_slt;
    logic                res_from_mem;
    logic                gr_we;

    modport src (
        output valid, pc, snpc, rs1_value, rs2_value, imm, alu_op, cmp_fn, mem_re, mem_we,
        output rd, src1_is_pc, src1_is_zero, src2_is_imm, is_branch, is_jump, is_slt,
        output res_from_mem, gr_we
    );
    modport dst (
        input valid, pc, snpc, rs1_value, rs2_value, imm, alu_op, cmp_fn, mem_re, mem_we,
        input rd, src1_is_pc, src1_is_zero, src2_is_imm, is_branch, is_jump, is_slt,
        input res_from_mem, gr_we
    );
endinterface

/* hw/deu_capture.sv */
`timescale 1ns/100ps

module deu_capture (
    input  logic           clock,
    input  logic           rst_i,
    input  logic           valid_i,
    input  deu_pkg::word_t pc_i,
    input  deu_pkg::word_t snpc_i,
    input  deu_pkg::word_t inst_i,
    input  deu_pkg::word_t rs1_value_i,
    input  deu_pkg::word_t rs2_value_i,
    fetch_if.src           out_o
);

    always_ff @(posedge clock) begin
        if (rst_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= valid_i;
        end
    end

    // payload holds across bubbles
    always_ff @(posedge clock) begin
        if (valid_i) begin
            out_o.pc        <= pc_i;
            out_o.snpc      <= snpc_i;
            out_o.inst      <= inst_i;
            out_o.rs1_value <= rs1_value_i;
            out_o.rs2_value <= rs2_value_i;
        end
    end

endmodule

/* hw/deu_field_decode.sv */
`timescale 1ns/100ps
`include "deu_defs.svh"

module deu_field_decode (
    input  logic    clock,
    input  logic    rst_i,
    fetch_if.dst    in_i,
    decoded_if.src  out_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    deu_pkg::word_t      imm_i;
    deu_pkg::word_t      imm_s;
    deu_pkg::word_t      imm_b;
    deu_pkg::word_t      imm_u;
    deu_pkg::word_t      imm_j;
    deu_pkg::word_t      imm;
    logic                op_imm;
    logic                op_reg;
    logic                op_load;
    logic                op_store;
    logic                op_branch;
    logic                f7_zero;
    logic                f7_alt;
    logic                inst_lui;
    logic                inst_auipc;
    logic                inst_jal;
    logic                inst_jalr;
    logic                inst_load;
    logic                inst_store;
    logic                inst_branch;
    logic                inst_add;
    logic                inst_sub;
    logic                inst_xor;
    logic                inst_or;
    logic                inst_and;
    logic                inst_sll;
    logic                inst_srl;
    logic                inst_sra;
    logic                inst_slt;
    logic                inst_sltu;
    logic                recognised;
    deu_pkg::alu_op_t    alu_op;
    deu_pkg::cmp_fn_t    cmp_fn;
    deu_pkg::mem_mask_t  mem_re;
    deu_pkg::mem_mask_t  mem_we;

    assign opcode = in_i.inst[6:0];
    assign funct3 = in_i.inst[14:12];
    assign funct7 = in_i.inst[31:25];

    assign imm_i = {{20{in_i.inst[31]}}, in_i.inst[31:20]};
    assign imm_s = {{20{in_i.inst[31]}}, in_i.inst[31:25], in_i.inst[11:7]};
    assign imm_b = {{19{in_i.inst[31]}}, in_i.inst[31], in_i.inst[7], in_i.inst[30:25],
                    in_i.inst[11:8], 1'b0};
    assign imm_u = {in_i.inst[31:12], 12'b0};
    assign imm_j = {{12{in_i.inst[31]}}, in_i.inst[19:12], in_i.inst[20], in_i.inst[30:21],
                    1'b0};

    assign op_imm    = opcode == `DEU_OP_IMM;
    assign op_reg    = opcode == `DEU_OP_REG;
    assign op_load   = opcode == `DEU_OP_LOAD;
    assign op_store  = opcode == `DEU_OP_STORE;
    assign op_branch = opcode == `DEU_OP_BRANCH;
    assign f7_zero   = funct7 == 7'b0000000;
    assign f7_alt    = funct7 == 7'b0100000;

    // immediate chosen by format
    always_comb begin
        case (opcode)
            `DEU_OP_LUI, `DEU_OP_AUIPC:           imm = imm_u;
            `DEU_OP_JAL:                          imm = imm_j;
            `DEU_OP_STORE:                        imm = imm_s;
            `DEU_OP_BRANCH:                       imm = imm_b;
            `DEU_OP_JALR, `DEU_OP_LOAD, `DEU_OP_IMM: imm = imm_i;
            default:                              imm = '0;
        endcase
    end

    assign inst_lui    = opcode == `DEU_OP_LUI;
    assign inst_auipc  = opcode == `DEU_OP_AUIPC;
    assign inst_jal    = opcode == `DEU_OP_JAL;
    assign inst_jalr   = opcode == `DEU_OP_JALR && funct3 == 3'b000;
    assign inst_load   = op_load && (funct3 == 3'b000 || funct3 == 3'b001 ||
                                     funct3 == 3'b010 || funct3 == 3'b100 || funct3 == 3'b101);
    assign inst_store  = op_store && (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010);
    assign inst_branch = op_branch && funct3 != 3'b010 && funct3 != 3'b011;

    // immediate and register forms share funct3
    assign inst_add  = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b000;
    assign inst_sub  = op_reg && f7_alt && funct3 == 3'b000;
    assign inst_xor  = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b100;
    assign inst_or   = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b110;
    assign inst_and  = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b111;
    assign inst_sll  = (op_imm || op_reg) && f7_zero && funct3 == 3'b001;
    assign inst_srl  = (op_imm || op_reg) && f7_zero && funct3 == 3'b101;
    assign inst_sra  = (op_imm || op_reg) && f7_alt && funct3 == 3'b101;
    assign inst_slt  = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b010;
    assign inst_sltu = (op_imm || (op_reg && f7_zero)) && funct3 == 3'b011;

    assign recognised = inst_lui || inst_auipc || inst_jal || inst_jalr || inst_load ||
                        inst_store || inst_branch || inst_add || inst_sub || inst_xor ||
                        inst_or || inst_and || inst_sll || inst_srl || inst_sra ||
                        inst_slt || inst_sltu;

    assign alu_op = {6{inst_lui || inst_auipc || inst_jal || inst_jalr || inst_load ||
                       inst_store || inst_branch || inst_add}} & `DEU_ALU_ADD |
                    {6{inst_sub}} & `DEU_ALU_SUB |
                    {6{inst_xor}} & `DEU_ALU_XOR |
                    {6{inst_or}}  & `DEU_ALU_OR  |
                    {6{inst_and}} & `DEU_ALU_AND |
                    {6{inst_sll}} & `DEU_ALU_SLL |
                    {6{inst_srl}} & `DEU_ALU_SRL |
                    {6{inst_sra}} & `DEU_ALU_SRA;

    assign cmp_fn = {3{inst_branch && funct3 == 3'b001}} & `DEU_CMP_NE  |
                    {3{inst_branch && funct3 == 3'b100}} & `DEU_CMP_LT  |
                    {3{inst_branch && funct3 == 3'b101}} & `DEU_CMP_GE  |
                    {3{inst_branch && funct3 == 3'b110}} & `DEU_CMP_LTU |
                    {3{inst_branch && funct3 == 3'b111}} & `DEU_CMP_GEU |
                    {3{inst_slt}}                        & `DEU_CMP_LT  |
                    {3{inst_sltu}}                       & `DEU_CMP_LTU;

    // lb, lh and lw carry a sign-extend lane bit
    assign mem_re = {4{inst_load && funct3 == 3'b000}} & 4'b0101 |
                    {4{inst_load && funct3 == 3'b001}} & 4'b0111 |
                    {4{inst_load && funct3 == 3'b010}} & 4'b1111 |
                    {4{inst_load && funct3 == 3'b100}} & 4'b0001 |
                    {4{inst_load && funct3 == 3'b101}} & 4'b0011;

    assign mem_we = {4{inst_store && funct3 == 3'b000}} & 4'b0001 |
                    {4{inst_store && funct3 == 3'b001}} & 4'b0011 |
                    {4{inst_store && funct3 == 3'b010}} & 4'b1111;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= in_i.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_i.valid) begin
            out_o.pc           <= in_i.pc;
            out_o.snpc         <= in_i.snpc;
            out_o.rs1_value    <= in_i.rs1_value;
            out_o.rs2_value    <= in_i.rs2_value;
            out_o.imm          <= imm;
            out_o.alu_op       <= alu_op;
            out_o.cmp_fn       <= cmp_fn;
            out_o.mem_re       <= mem_re;
            out_o.mem_we       <= mem_we;
            out_o.rd           <= in_i.inst[11:7];
            out_o.src1_is_pc   <= inst_jal || inst_branch || inst_auipc;
            out_o.src1_is_zero <= inst_lui;
            out_o.src2_is_imm  <= recognised && !op_reg;
            out_o.is_branch    <= inst_branch;
            out_o.is_jump      <= inst_jal || inst_jalr;
            out_o.is_slt       <= inst_slt || inst_sltu;
            out_o.res_from_mem <= inst_load;
            out_o.gr_we        <= recognised && !inst_store && !inst_branch;
        end
    end

endmodule

/* hw/deu_operand_select.sv */
`timescale 1ns/100ps
`include "deu_defs.svh"

module deu_operand_select (
    input  logic                clock,
    input  logic                rst_i,
    decoded_if.dst              in_i,
    output logic                valid_o,
    output deu_pkg::word_t      src1_o,
    output deu_pkg::word_t      src2_o,
    output deu_pkg::word_t      store_data_o,
    output deu_pkg::alu_op_t    alu_op_o,
    output logic                res_from_mem_o,
    output logic                gr_we_o,
    output deu_pkg::mem_mask_t  mem_re_o,
    output deu_pkg::mem_mask_t  mem_we_o,
    output deu_pkg::reg_idx_t   rd_o,
    output logic                jmp_o,
    output logic                res_from_pre_o,
    output deu_pkg::word_t      final_result_o
);

    deu_pkg::word_t src1;
    deu_pkg::word_t src2;
    deu_pkg::word_t cmp_b;
    deu_pkg::word_t final_result;
    logic           cmp_true;

    always_comb begin
        if (in_i.src1_is_pc) begin
            src1 = in_i.pc;
        end else if (in_i.src1_is_zero) begin
            src1 = '0;
        end else begin
            src1 = in_i.rs1_value;
        end
    end

    assign src2 = in_i.src2_is_imm ? in_i.imm : in_i.rs2_value;

    // slti and sltiu compare against the immediate, branches against rs2
    assign cmp_b = (in_i.is_slt && in_i.src2_is_imm) ? in_i.imm : in_i.rs2_value;

    always_comb begin
        case (in_i.cmp_fn)
            `DEU_CMP_EQ:  cmp_true = in_i.rs1_value == cmp_b;
            `DEU_CMP_NE:  cmp_true = in_i.rs1_value != cmp_b;
            `DEU_CMP_LT:  cmp_true = $signed(in_i.rs1_value) < $signed(cmp_b);
            `DEU_CMP_GE:  cmp_true = $signed(in_i.rs1_value) >= $signed(cmp_b);
            `DEU_CMP_LTU: cmp_true = in_i.rs1_value < cmp_b;
            `DEU_CMP_GEU: cmp_true = in_i.rs1_value >= cmp_b;
            default:      cmp_true = 1'b0;
        endcase
    end

    always_comb begin
        if (in_i.is_jump) begin
            final_result = in_i.snpc;
        end else if (in_i.is_slt) begin
            final_result = {{(`DEU_XLEN-1){1'b0}}, cmp_true};
        end else begin
            final_result = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= in_i.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_i.valid) begin
            src1_o         <= src1;
            src2_o         <= src2;
            store_data_o   <= in_i.rs2_value;
            alu_op_o       <= in_i.alu_op;
            res_from_mem_o <= in_i.res_from_mem;
            gr_we_o        <= in_i.gr_we;
            mem_re_o       <= in_i.mem_re;
            mem_we_o       <= in_i.mem_we;
            rd_o           <= in_i.rd;
            jmp_o          <= in_i.is_jump || (in_i.is_branch && cmp_true);
            res_from_pre_o <= in_i.is_jump || in_i.is_slt;
            final_result_o <= final_result;
        end
    end

endmodule

/* hw/deu.sv */
`timescale 1ns/100ps

module deu (
    input  logic                clock,
    input  logic                rst_i,
    input  logic                valid_i,
    input  deu_pkg::word_t      pc_i,
    input  deu_pkg::word_t      snpc_i,
    input  deu_pkg::word_t      inst_i,
    input  deu_pkg::word_t      rs1_value_i,
    input  deu_pkg::word_t      rs2_value_i,
    output logic                valid_o,
    output deu_pkg::word_t      src1_o,
    output deu_pkg::word_t      src2_o,
    output deu_pkg::word_t      store_data_o,
    output deu_pkg::alu_op_t    alu_op_o,
    output logic                res_from_mem_o,
    output logic                gr_we_o,
    output deu_pkg::mem_mask_t  mem_re_o,
    output deu_pkg::mem_mask_t  mem_we_o,
    output deu_pkg::reg_idx_t   rd_o,
    output logic                jmp_o,
    output logic                res_from_pre_o,
    output deu_pkg::word_t      final_result_o
);

    fetch_if   fetch_bus ();
    decoded_if decoded_bus ();

    deu_capture capture_i (
        .clock       (clock),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .snpc_i      (snpc_i),
        .inst_i      (inst_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .out_o       (fetch_bus.src)
    );

    deu_field_decode field_decode_i (
        .clock (clock),
        .rst_i (rst_i),
        .in_i  (fetch_bus.dst),
        .out_o (decoded_bus.src)
    );

    deu_operand_select operand_select_i (
        .clock          (clock),
        .rst_i          (rst_i),
        .in_i           (decoded_bus.dst),
        .valid_o        (valid_o),
        .src1_o         (src1_o),
        .src2_o         (src2_o),
        .store_data_o   (store_data_o),
        .alu_op_o       (alu_op_o),
        .res_from_mem_o (res_from_mem_o),
        .gr_we_o        (gr_we_o),
        .mem_re_o       (mem_re_o),
        .mem_we_o       (mem_we_o),
        .rd_o           (rd_o),
        .jmp_o          (jmp_o),
        .res_from_pre_o (res_from_pre_o),
        .final_result_o (final_result_o)
    );

endmodule

/* bench/deu_ref_model.svh */
`ifndef DEU_REF_MODEL_SVH
`define DEU_REF_MODEL_SVH

typedef struct packed {
    deu_pkg::word_t     src1;
    deu_pkg::word_t     src2;
    deu_pkg::word_t     store_data;
    deu_pkg::alu_op_t   alu_op;
    logic               res_from_mem;
    logic               gr_we;
    deu_pkg::mem_mask_t mem_re;
    deu_pkg::mem_mask_t mem_we;
    deu_pkg::reg_idx_t  rd;
    logic               jmp;
    logic               res_from_pre;
    deu_pkg::word_t     final_result;
} decode_result_t;

// one random instruction word, about one in eight unrecognised
function automatic deu_pkg::word_t gen_inst();
    deu_pkg::word_t word;
    logic [2:0]     pick;
    word = rand_bits(32);
    if (rand_bits(3) == 3'd0) begin
        // either noise or an M-extension op
        if (rand_bits(1) == 1'b1) begin
            word = {7'b0000001, word[24:7], `DEU_OP_REG};
        end
    end else begin
        case (rand_bits(4) % 9)
            0: word[6:0] = `DEU_OP_LUI;
            1: word[6:0] = `DEU_OP_AUIPC;
            2: word[6:0] = `DEU_OP_JAL;
            3: begin
                word[6:0] = `DEU_OP_JALR;
                word[14:12] = 3'b000;
            end
            4: begin
                word[6:0] = `DEU_OP_LOAD;
                pick = 3'(rand_bits(3) % 5);
                word[14:12] = (pick < 3) ? pick : pick + 3'd1;
            end
            5: begin
                word[6:0] = `DEU_OP_STORE;
                word[14:12] = 3'(rand_bits(2) % 3);
            end
            6: begin
                word[6:0] = `DEU_OP_BRANCH;
                pick = 3'(rand_bits(3) % 6);
                word[14:12] = (pick < 2) ? pick : pick + 3'd2;
            end
            7: begin
                word[6:0] = `DEU_OP_IMM;
                if (word[14:12] == 3'b001) begin
                    word[31:25] = 7'b0000000;
                end
                if (word[14:12] == 3'b101) begin
                    word[31:25] = {1'b0, word[30], 5'b00000};
                end
            end
            default: begin
                word[6:0] = `DEU_OP_REG;
                if (word[14:12] == 3'b000 || word[14:12] == 3'b101) begin
                    word[31:25] = {1'b0, word[30], 5'b00000};
                end else begin
                    word[31:25] = 7'b0000000;
                end
            end
        endcase
    end
    return word;
endfunction

// branch outcome by funct3
function automatic logic branch_taken(input logic [2:0] f3, input deu_pkg::word_t a,
                                     input deu_pkg::word_t b);
    case (f3)
        3'b000:  branch_taken = a == b;
        3'b001:  branch_taken = a != b;
        3'b100:  branch_taken = $signed(a) < $signed(b);
        3'b101:  branch_taken = $signed(a) >= $signed(b);
        3'b110:  branch_taken = a < b;
        3'b111:  branch_taken = a >= b;
        default: branch_taken = 1'b0;
    endcase
endfunction

function automatic decode_result_t model_decode(input deu_pkg::word_t inst,
                                                input deu_pkg::word_t pc,
                                                input deu_pkg::word_t snpc,
                                                input deu_pkg::word_t rs1,
                                                input deu_pkg::word_t rs2);
    decode_result_t r;
    logic [2:0]     f3;
    logic [6:0]     f7;
    logic           is_reg;
    logic           legal;
    deu_pkg::word_t imm_i;
    deu_pkg::word_t imm_s;
    deu_pkg::word_t imm_b;
    deu_pkg::word_t imm_u;
    deu_pkg::word_t imm_j;
    deu_pkg::word_t opnd_b;
    f3 = inst[14:12];
    f7 = inst[31:25];
    imm_i = $signed(inst) >>> 20;
    imm_s = {imm_i[31:5], inst[11:7]};
    imm_b = {imm_i[31:12], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'h000};
    imm_j = {imm_i[31:20], inst[19:12], inst[20], inst[30:21], 1'b0};
    r = '0;
    r.src1 = rs1;
    r.src2 = rs2;
    r.store_data = rs2;
    r.rd = inst[11:7];
    case (inst[6:0])
        `DEU_OP_LUI, `DEU_OP_AUIPC: begin
            r.alu_op = `DEU_ALU_ADD;
            r.src1 = (inst[6:0] == `DEU_OP_LUI) ? 32'h0 : pc;
            r.src2 = imm_u;
            r.gr_we = 1'b1;
        end
        `DEU_OP_JAL, `DEU_OP_JALR: begin
            if (inst[6:0] == `DEU_OP_JAL || f3 == 3'b000) begin
                r.alu_op = `DEU_ALU_ADD;
                r.src1 = (inst[6:0] == `DEU_OP_JAL) ? pc : rs1;
                r.src2 = (inst[6:0] == `DEU_OP_JAL) ? imm_j : imm_i;
                r.gr_we = 1'b1;
                r.jmp = 1'b1;
                r.res_from_pre = 1'b1;
                r.final_result = snpc;
            end
        end
        `DEU_OP_LOAD: begin
            case (f3)
                3'b000:  r.mem_re = 4'b0101;
                3'b001:  r.mem_re = 4'b0111;
                3'b010:  r.mem_re = 4'b1111;
                3'b100:  r.mem_re = 4'b0001;
                3'b101:  r.mem_re = 4'b0011;
                default: r.mem_re = 4'b0000;
            endcase
            if (r.mem_re != 4'b0000) begin
                r.alu_op = `DEU_ALU_ADD;
                r.src2 = imm_i;
                r.gr_we = 1'b1;
                r.res_from_mem = 1'b1;
            end
        end
        `DEU_OP_STORE: begin
            if (f3 <= 3'b010) begin
                r.mem_we = (f3 == 3'b010) ? 4'b1111 : (f3 == 3'b001) ? 4'b0011 : 4'b0001;
                r.alu_op = `DEU_ALU_ADD;
                r.src2 = imm_s;
            end
        end
        `DEU_OP_BRANCH: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                r.alu_op = `DEU_ALU_ADD;
                r.src1 = pc;
                r.src2 = imm_b;
                r.jmp = branch_taken(f3, rs1, rs2);
            end
        end
        `DEU_OP_IMM, `DEU_OP_REG: begin
            is_reg = inst[6:0] == `DEU_OP_REG;
            opnd_b = is_reg ? rs2 : imm_i;
            if (is_reg) begin
                legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            end else begin
                legal = (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00 ||
                        (f7 == 7'h20 && f3 == 3'b101);
            end
            if (legal) begin
                r.src2 = opnd_b;
                r.gr_we = 1'b1;
                case (f3)
                    3'b000: r.alu_op = (is_reg && f7[5]) ? `DEU_ALU_SUB : `DEU_ALU_ADD;
                    3'b001: r.alu_op = `DEU_ALU_SLL;
                    3'b010: begin
                        r.res_from_pre = 1'b1;
                        r.final_result = {31'b0, $signed(rs1) < $signed(opnd_b)};
                    end
                    3'b011: begin
                        r.res_from_pre = 1'b1;
                        r.final_result = {31'b0, rs1 < opnd_b};
                    end
                    3'b100: r.alu_op = `DEU_ALU_XOR;
                    3'b101: r.alu_op = f7[5] ? `DEU_ALU_SRA : `DEU_ALU_SRL;
                    3'b110: r.alu_op = `DEU_ALU_OR;
                    default: r.alu_op = `DEU_ALU_AND;
                endcase
            end
        end
        default: ;
    endcase
    return r;
endfunction

`endif

/* bench/deu_tb.sv */
`timescale 1ns/100ps
`include "deu_defs.svh"

module deu_tb;

    localparam int NUM_INSTS = 2000;
    // stimulus slots plus a quarter for reset, idle and drain
    localparam int MAX_CYCLES = NUM_INSTS + NUM_INSTS / 4;

    logic [15:0] lfsr_state = 16'd58095;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

`include "deu_ref_model.svh"

    logic               clock;
    logic               rst_i;
    logic               valid_i;
    deu_pkg::word_t     pc_i;
    deu_pkg::word_t     snpc_i;
    deu_pkg::word_t     inst_i;
    deu_pkg::word_t     rs1_value_i;
    deu_pkg::word_t     rs2_value_i;
    logic               valid_o;
    deu_pkg::word_t     src1_o;
    deu_pkg::word_t     src2_o;
    deu_pkg::word_t     store_data_o;
    deu_pkg::alu_op_t   alu_op_o;
    logic               res_from_mem_o;
    logic               gr_we_o;
    deu_pkg::mem_mask_t mem_re_o;
    deu_pkg::mem_mask_t mem_we_o;
    deu_pkg::reg_idx_t  rd_o;
    logic               jmp_o;
    logic               res_from_pre_o;
    deu_pkg::word_t     final_result_o;

    decode_result_t expected_q[$];
    logic [2:0]     sent_hist = 3'b000;
    logic           out_of_reset = 1'b0;
    int             cycle_count = 0;

    deu dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        sent_hist <= {sent_hist[1:0], valid_i};
        out_of_reset <= !rst_i;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // outputs settle after the rising edge
    always @(negedge clock) begin : compare_outputs
        decode_result_t exp_item;
        if (out_of_reset) begin
            check_value("valid_o", valid_o, sent_hist[2]);
            if (valid_o === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("valid_o is high but no instruction is outstanding");
                    abort_run();
                end else begin
                    exp_item = expected_q.pop_front();
                    check_value("src1_o", src1_o, exp_item.src1);
                    check_value("src2_o", src2_o, exp_item.src2);
                    check_value("store_data_o", store_data_o, exp_item.store_data);
                    check_value("alu_op_o", alu_op_o, exp_item.alu_op);
                    check_value("res_from_mem_o", res_from_mem_o, exp_item.res_from_mem);
                    check_value("gr_we_o", gr_we_o, exp_item.gr_we);
                    check_value("mem_re_o", mem_re_o, exp_item.mem_re);
                    check_value("mem_we_o", mem_we_o, exp_item.mem_we);
                    check_value("rd_o", rd_o, exp_item.rd);
                    check_value("jmp_o", jmp_o, exp_item.jmp);
                    check_value("res_from_pre_o", res_from_pre_o, exp_item.res_from_pre);
                    check_value("final_result_o", final_result_o, exp_item.final_result);
                end
            end
        end
    end

    initial begin
        deu_pkg::word_t inst;
        deu_pkg::word_t pc;
        deu_pkg::word_t rs1;
        deu_pkg::word_t rs2;
        logic           send;
        rst_i = 1'b1;
        valid_i = 1'b0;
        pc_i = '0;
        snpc_i = '0;
        inst_i = '0;
        rs1_value_i = '0;
        rs2_value_i = '0;
        repeat (4) @(negedge clock);
        rst_i = 1'b0;
        // idle, valid_o must stay low
        repeat (5) @(negedge clock);
        for (int n = 0; n < NUM_INSTS; n++) begin
            send = rand_bits(2) != 2'b00;
            inst = gen_inst();
            pc = rand_bits(30) << 2;
            rs1 = rand_bits(32);
            // equal operands now and then so eq and ge get hit
            if (rand_bits(2) == 2'b00) begin
                rs2 = rs1;
            end else begin
                rs2 = rand_bits(32);
            end
            valid_i = send;
            pc_i = pc;
            snpc_i = pc + 32'd4;
            inst_i = inst;
            rs1_value_i = rs1;
            rs2_value_i = rs2;
            if (send) begin
                expected_q.push_back(model_decode(inst, pc, pc + 32'd4, rs1, rs2));
            end
            @(negedge clock);
        end
        valid_i = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* deu.f */
+incdir+hw
+incdir+bench
hw/deu_pkg.sv
hw/deu_stage_if.sv
hw/deu_capture.sv
hw/deu_field_decode.sv
hw/deu_operand_select.sv
hw/deu.sv
bench/deu_tb.sv

/* Bender.yml */
package:
  name: deu

sources:
  - include_dirs:
      - hw
    files:
      - hw/deu_pkg.sv
      - hw/deu_stage_if.sv
      - hw/deu_capture.sv
      - hw/deu_field_decode.sv
      - hw/deu_operand_select.sv
      - hw/deu.sv
  - target: test
    include_dirs:
      - hw
      - bench
    files:
      - bench/deu_tb.sv
